// ==== design/cursor_pkg.sv ====
package cursor_pkg;

    // per-axis step command from the conditioner
    typedef enum logic [1:0] {
        MOVE_NONE = 2'd0,
        MOVE_INC  = 2'd1,
        MOVE_DEC  = 2'd2
    } move_e;

    // opposite buttons cancel out
    function automatic move_e resolve_move(input logic inc, input logic dec);
        move_e m;
        m = MOVE_NONE;
        if (inc && !dec) begin
            m = MOVE_INC;
        end else if (dec && !inc) begin
            m = MOVE_DEC;
        end
        return m;
    endfunction

    // centre of the saturation range
    function automatic int mid_point(input int lo, input int hi);
        return (lo + hi) / 2;
    endfunction

endpackage

// ==== design/axil_pkg.sv ====
package axil_pkg;

    localparam int ADDR_W = 4;   // byte address bits
    localparam int DATA_W = 32;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // register map
    typedef enum logic [ADDR_W-1:0] {
        REG_POS    = 4'h0,   // read pops queue head
        REG_STATUS = 4'h4,
        REG_CUR    = 4'h8,   // live position
        REG_CTRL   = 4'hC    // write only
    } reg_addr_e;

endpackage

// ==== design/button_conditioner.sv ====
`timescale 1ns/100ps

module button_conditioner #(
    parameter int REPEAT_CYCLES = 16
)(
    input  logic                clk,
    input  logic                rst,
    input  logic                btn_r,
    input  logic                btn_l,
    input  logic                btn_u,
    input  logic                btn_d,
    input  logic                btn_c,
    output cursor_pkg::move_e   move_x,
    output cursor_pkg::move_e   move_y,
    output logic                center
);

    localparam int CNT_W = $clog2(REPEAT_CYCLES + 1);

    // bit order {c, d, u, l, r}
    logic [4:0]       sync1;
    logic [4:0]       sync2;
    logic [4:0]       prev;
    logic [4:0]       rise;
    logic             any_held;
    logic             tick;
    logic             step;
    logic [CNT_W-1:0] rep_cnt;

    assign rise     = sync2 & ~prev;
    assign any_held = |sync2;
    assign tick     = any_held && (rep_cnt == CNT_W'(REPEAT_CYCLES - 1));
    assign step     = (|rise) || tick;   // press edge or repeat wrap

    always_ff @(posedge clk) begin
        if (rst) begin
            sync1   <= '0;
            sync2   <= '0;
            prev    <= '0;
            rep_cnt <= '0;
            move_x  <= cursor_pkg::MOVE_NONE;
            move_y  <= cursor_pkg::MOVE_NONE;
            center  <= 1'b0;
        end else begin
            sync1 <= {btn_c, btn_d, btn_u, btn_l, btn_r};
            sync2 <= sync1;
            prev  <= sync2;

            // any new press restarts the shared repeat interval
            if ((|rise) || !any_held || tick) begin
                rep_cnt <= '0;
            end else begin
                rep_cnt <= rep_cnt + 1'b1;
            end

            center <= step && sync2[4];
            if (step && !sync2[4]) begin   // centre wins over moves
                move_x <= cursor_pkg::resolve_move(sync2[0], sync2[1]);
                move_y <= cursor_pkg::resolve_move(sync2[2], sync2[3]);
            end else begin
                move_x <= cursor_pkg::MOVE_NONE;
                move_y <= cursor_pkg::MOVE_NONE;
            end
        end
    end

endmodule

// ==== design/cursor_tracker.sv ====
`timescale 1ns/100ps

module cursor_tracker #(
    parameter int OUTWIDTH = 8,
    parameter int STEP     = 1,
    parameter int MINVAL   = 10,
    parameter int MAXVAL   = 245
)(
    input  logic                clk,
    input  logic                rst,
    input  cursor_pkg::move_e   move_x,
    input  cursor_pkg::move_e   move_y,
    input  logic                center,
    output logic [OUTWIDTH-1:0] x,
    output logic [OUTWIDTH-1:0] y,
    output logic                update
);

    localparam logic [OUTWIDTH-1:0] MIN_V = OUTWIDTH'(MINVAL);
    localparam logic [OUTWIDTH-1:0] MAX_V = OUTWIDTH'(MAXVAL);
    localparam logic [OUTWIDTH-1:0] MID_V = OUTWIDTH'(cursor_pkg::mid_point(MINVAL, MAXVAL));

    logic [OUTWIDTH-1:0] x_d;
    logic [OUTWIDTH-1:0] y_d;

    // one step along an axis, clipped to [MINVAL, MAXVAL]
    function automatic logic [OUTWIDTH-1:0] next_coord(
        input logic [OUTWIDTH-1:0] val,
        input cursor_pkg::move_e   m
    );
        logic [OUTWIDTH-1:0] res;
        res = val;
        case (m)
            cursor_pkg::MOVE_INC: begin
                if (int'(val) + STEP > MAXVAL) res = MAX_V;
                else res = val + OUTWIDTH'(STEP);
            end
            cursor_pkg::MOVE_DEC: begin
                if (int'(val) - STEP < MINVAL) res = MIN_V;
                else res = val - OUTWIDTH'(STEP);
            end
            default: res = val;
        endcase
        return res;
    endfunction

    always_comb begin
        if (center) begin
            x_d = MID_V;
            y_d = MID_V;
        end else begin
            x_d = next_coord(x, move_x);
            y_d = next_coord(y, move_y);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            x      <= MID_V;
            y      <= MID_V;
            update <= 1'b0;
        end else begin
            x      <= x_d;
            y      <= y_d;
            update <= (x_d != x) || (y_d != y);   // no pulse when pinned at a limit
        end
    end

endmodule

// ==== design/position_fifo.sv ====
`timescale 1ns/100ps

module position_fifo #(
    parameter int OUTWIDTH   = 8,
    parameter int FIFO_DEPTH = 8
)(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  logic [2*OUTWIDTH-1:0] push_data,
    input  logic                  pop,
    input  logic                  clear_overflow,
    output logic [2*OUTWIDTH-1:0] head,
    output logic [7:0]            count,
    output logic                  empty,
    output logic                  overflow
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    logic [2*OUTWIDTH-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic                  full;
    logic                  do_pop;
    logic                  do_push;

    assign empty   = (count == 8'd0);
    assign full    = (count == 8'(FIFO_DEPTH));
    assign head    = mem[rd_ptr];
    assign do_pop  = pop && !empty;
    assign do_push = push && (!full || do_pop);   // full FIFO still takes push with pop

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + {7'd0, do_push} - {7'd0, do_pop};
            if (push && !do_push) begin
                overflow <= 1'b1;   // dropped entry, set wins over clear
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

// ==== design/axil_position_regs.sv ====
`timescale 1ns/100ps

module axil_position_regs #(
    parameter int OUTWIDTH = 8
)(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [axil_pkg::DATA_W-1:0]   wdata,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [axil_pkg::ADDR_W-1:0]   araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [axil_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                    rresp,
    input  logic [OUTWIDTH-1:0]           x,
    input  logic [OUTWIDTH-1:0]           y,
    input  logic [2*OUTWIDTH-1:0]         head,
    input  logic [7:0]                    count,
    input  logic                          empty,
    input  logic                          overflow,
    output logic                          pop,
    output logic                          clear_overflow
);

    axil_pkg::reg_addr_e rd_addr;
    axil_pkg::reg_addr_e wr_addr;
    logic                rd_fire;
    logic                wr_fire;

    assign rd_addr = axil_pkg::reg_addr_e'(araddr);
    assign wr_addr = axil_pkg::reg_addr_e'(awaddr);

    assign arready = !rvalid;   // one read in flight
    assign rd_fire = arvalid && arready;

    // aw and w accepted together only
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;

    assign pop            = rd_fire && (rd_addr == axil_pkg::REG_POS) && !empty;
    assign clear_overflow = wr_fire && (wr_addr == axil_pkg::REG_CTRL) && wdata[0];

    // read response, payload held until rready
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= '0;
            rresp <= axil_pkg::RESP_OKAY;
            case (rd_addr)
                axil_pkg::REG_POS: begin
                    if (empty) rresp <= axil_pkg::RESP_SLVERR;
                    else rdata <= axil_pkg::DATA_W'(head);   // head popped this cycle
                end
                axil_pkg::REG_STATUS: rdata <= {23'd0, overflow, count};
                axil_pkg::REG_CUR:    rdata <= axil_pkg::DATA_W'({y, x});
                default:              rresp <= axil_pkg::RESP_SLVERR;
            endcase
        end
    end

    // write response
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            if (wr_addr == axil_pkg::REG_CTRL) bresp <= axil_pkg::RESP_OKAY;
            else bresp <= axil_pkg::RESP_SLVERR;   // everything else is read only or unmapped
        end
    end

endmodule

// ==== design/cursor_subsystem.sv ====
`timescale 1ns/100ps

module cursor_subsystem #(
    parameter int OUTWIDTH      = 8,
    parameter int STEP          = 1,
    parameter int MINVAL        = 10,
    parameter int MAXVAL        = 245,
    parameter int REPEAT_CYCLES = 16,
    parameter int FIFO_DEPTH    = 8
)(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          btn_r,
    input  logic                          btn_l,
    input  logic                          btn_u,
    input  logic                          btn_d,
    input  logic                          btn_c,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [axil_pkg::ADDR_W-1:0]   awaddr,
    input  logic                          wvalid,
    output logic                          wready,
    input  logic [axil_pkg::DATA_W-1:0]   wdata,
    output logic                          bvalid,
    input  logic                          bready,
    output logic [1:0]                    bresp,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [axil_pkg::ADDR_W-1:0]   araddr,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [axil_pkg::DATA_W-1:0]   rdata,
    output logic [1:0]                    rresp
);

    cursor_pkg::move_e     move_x;
    cursor_pkg::move_e     move_y;
    logic                  center;
    logic [OUTWIDTH-1:0]   x;
    logic [OUTWIDTH-1:0]   y;
    logic                  update;
    logic [2*OUTWIDTH-1:0] head;
    logic [7:0]            count;
    logic                  empty;
    logic                  overflow;
    logic                  pop;
    logic                  clear_overflow;

    button_conditioner #(.REPEAT_CYCLES(REPEAT_CYCLES)) u_cond (
        .clk(clk), .rst(rst),
        .btn_r(btn_r), .btn_l(btn_l), .btn_u(btn_u), .btn_d(btn_d), .btn_c(btn_c),
        .move_x(move_x), .move_y(move_y), .center(center)
    );

    cursor_tracker #(
        .OUTWIDTH(OUTWIDTH), .STEP(STEP), .MINVAL(MINVAL), .MAXVAL(MAXVAL)
    ) u_tracker (
        .clk(clk), .rst(rst),
        .move_x(move_x), .move_y(move_y), .center(center),
        .x(x), .y(y), .update(update)
    );

    // queue entry is the packed position, x in the low half
    position_fifo #(.OUTWIDTH(OUTWIDTH), .FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk(clk), .rst(rst),
        .push(update), .push_data({y, x}),
        .pop(pop), .clear_overflow(clear_overflow),
        .head(head), .count(count), .empty(empty), .overflow(overflow)
    );

    axil_position_regs #(.OUTWIDTH(OUTWIDTH)) u_regs (
        .clk(clk), .rst(rst),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .x(x), .y(y), .head(head), .count(count), .empty(empty), .overflow(overflow),
        .pop(pop), .clear_overflow(clear_overflow)
    );

endmodule

// ==== verification/cursor_subsystem_tb.sv ====
`timescale 1ns/100ps

module cursor_subsystem_tb;

    localparam int OUTWIDTH      = 8;
    localparam int STEP          = 1;
    localparam int MINVAL        = 10;
    localparam int MAXVAL        = 245;
    localparam int MID           = (MINVAL + MAXVAL) / 2;
    localparam int REPEAT_CYCLES = 4;
    localparam int FIFO_DEPTH    = 8;
    localparam int SETTLE        = 8;   // sync, strobe, tracker and FIFO latency plus slack
    localparam int SAT_HOLD      = REPEAT_CYCLES * ((MAXVAL - MINVAL) / 2 + 8);
    // three long holds, about twenty taps and up to eighty bus transfers
    localparam int TIMEOUT_CYCLES = 3 * (SAT_HOLD + 16 + SETTLE)
                                  + 20 * (REPEAT_CYCLES + SETTLE + 2) + 80 * 16 + 200;
    localparam logic [3:0] UNMAPPED_ADDR = 4'h3;

    logic        clk;
    logic        rst;
    logic        btn_r;
    logic        btn_l;
    logic        btn_u;
    logic        btn_d;
    logic        btn_c;
    logic        awvalid;
    logic        awready;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    logic        arvalid;
    logic        arready;
    logic [3:0]  araddr;
    logic        rvalid;
    logic        rready;
    logic [31:0] rdata;
    logic [1:0]  rresp;

    // reference model state
    int          exp_x;
    int          exp_y;
    logic        exp_ovf;
    logic [31:0] exp_q[$];   // first FIFO_DEPTH entries not yet popped
    logic [31:0] lcg_state = 32'h3d4d_e5db;
    string       test_name;
    int          cycles = 0;

    cursor_subsystem #(
        .OUTWIDTH(OUTWIDTH), .STEP(STEP), .MINVAL(MINVAL), .MAXVAL(MAXVAL),
        .REPEAT_CYCLES(REPEAT_CYCLES), .FIFO_DEPTH(FIFO_DEPTH)
    ) DUT (
        .clk(clk), .rst(rst),
        .btn_r(btn_r), .btn_l(btn_l), .btn_u(btn_u), .btn_d(btn_d), .btn_c(btn_c),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles while the tests were still running", cycles);
            $display("** FAIL **");
            $fatal(1, "simulation did not finish in time");
        end
    end

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state >> 8);
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + (next_rand() % (hi - lo + 1));
    endfunction

    function automatic logic [31:0] pos_word(input int px, input int py);
        return 32'((py << OUTWIDTH) | px);   // x low and y above it
    endfunction

    function automatic int clip_step(input int v, input int dir);
        int n;
        n = v + dir * STEP;
        if (n > MAXVAL) n = MAXVAL;
        if (n < MINVAL) n = MINVAL;
        return n;
    endfunction

    // one strobe through the expected position and queue
    function automatic void model_strobe(input int dx, input int dy, input logic c);
        int nx;
        int ny;
        nx = c ? MID : clip_step(exp_x, dx);
        ny = c ? MID : clip_step(exp_y, dy);
        if (nx != exp_x || ny != exp_y) begin
            exp_x = nx;
            exp_y = ny;
            if (exp_q.size() < FIFO_DEPTH) exp_q.push_back(pos_word(nx, ny));
            else exp_ovf = 1'b1;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s expected 0x%08h actual 0x%08h", test_name, name, exp, act);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    // hold is the number of cycles rready stays low once rvalid is up
    task automatic axil_read(input logic [3:0] addr, input int hold,
                             output logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        arvalid = 1'b1;
        araddr  = addr;
        rready  = (hold == 0);
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_value("rvalid held", 32'd1, 32'(rvalid));
            check_value("rdata stable", data, rdata);
            check_value("rresp stable", 32'(resp), 32'(rresp));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] val,
                              output logic [1:0] resp);
        @(negedge clk);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = val;
        bready  = 1'b1;
        #1;
        while (!(awready && wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic press(input logic r, input logic l, input logic u, input logic d,
                         input logic c, input int hold);
        int strobes;
        int dx;
        int dy;
        strobes = 1 + (hold - 1) / REPEAT_CYCLES;   // press edge then one per interval
        dx = (r && !l) ? 1 : ((l && !r) ? -1 : 0);
        dy = (u && !d) ? 1 : ((d && !u) ? -1 : 0);
        @(negedge clk);
        {btn_r, btn_l, btn_u, btn_d, btn_c} = {r, l, u, d, c};
        repeat (hold) @(negedge clk);
        {btn_r, btn_l, btn_u, btn_d, btn_c} = 5'b0;
        repeat (SETTLE) @(negedge clk);
        repeat (strobes) model_strobe(dx, dy, c);
    endtask

    task automatic check_cur();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(axil_pkg::REG_CUR, 0, data, resp);
        check_value("cur resp", 32'(axil_pkg::RESP_OKAY), 32'(resp));
        check_value("cur position", pos_word(exp_x, exp_y), data);
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(axil_pkg::REG_STATUS, 0, data, resp);
        check_value("status resp", 32'(axil_pkg::RESP_OKAY), 32'(resp));
        check_value("status word", 32'((int'(exp_ovf) << 8) | exp_q.size()), data);
    endtask

    task automatic drain_and_check();
        logic [31:0] data;
        logic [1:0]  resp;
        while (exp_q.size() > 0) begin
            axil_read(axil_pkg::REG_POS, 0, data, resp);
            check_value("pop resp", 32'(axil_pkg::RESP_OKAY), 32'(resp));
            check_value("pop data", exp_q.pop_front(), data);
        end
        axil_read(axil_pkg::REG_POS, 0, data, resp);
        check_value("empty pop resp", 32'(axil_pkg::RESP_SLVERR), 32'(resp));
        check_value("empty pop data", 32'd0, data);
        check_status();
    endtask

    task automatic clear_overflow_bit();
        logic [1:0] resp;
        axil_write(axil_pkg::REG_CTRL, 32'd1, resp);
        check_value("ctrl write resp", 32'(axil_pkg::RESP_OKAY), 32'(resp));
        exp_ovf = 1'b0;
        check_status();
    endtask

    initial begin
        logic [31:0] data;
        logic [1:0]  resp;
        int          dir;
        {btn_r, btn_l, btn_u, btn_d, btn_c} = 5'b0;
        {awvalid, wvalid, bready, arvalid, rready} = 5'b0;
        awaddr  = '0;
        wdata   = '0;
        araddr  = '0;
        rst     = 1'b1;
        exp_x   = MID;
        exp_y   = MID;
        exp_ovf = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        test_name = "reset";
        check_cur();
        check_status();
        axil_read(axil_pkg::REG_POS, 0, data, resp);
        check_value("empty pop resp", 32'(axil_pkg::RESP_SLVERR), 32'(resp));

        test_name = "single_tap";
        press(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, rand_range(1, REPEAT_CYCLES));
        press(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, rand_range(1, REPEAT_CYCLES));
        check_status();
        check_cur();   // live position equals the newest entry
        drain_and_check();

        test_name = "saturation";
        // x is away from both limits here so either button winning would show
        press(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 3 * REPEAT_CYCLES + rand_range(1, 8));
        check_cur();
        check_status();
        press(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, SAT_HOLD + rand_range(0, 16));
        check_cur();
        drain_and_check();
        press(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, SAT_HOLD + rand_range(0, 16));
        check_cur();
        drain_and_check();
        clear_overflow_bit();

        test_name = "recenter";
        press(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, rand_range(1, REPEAT_CYCLES));
        check_cur();
        drain_and_check();

        test_name = "overflow";
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            dir = rand_range(0, 3);
            press(dir == 0, dir == 1, dir == 2, dir == 3, 1'b0, rand_range(1, REPEAT_CYCLES));
        end
        check_status();   // full count with the sticky bit
        drain_and_check();
        clear_overflow_bit();

        test_name = "bus_errors";
        axil_read(axil_pkg::REG_CTRL, 3, data, resp);
        check_value("ctrl read resp", 32'(axil_pkg::RESP_SLVERR), 32'(resp));
        axil_write(axil_pkg::REG_CUR, 32'h0000_1234, resp);
        check_value("cur write resp", 32'(axil_pkg::RESP_SLVERR), 32'(resp));
        axil_read(UNMAPPED_ADDR, 4, data, resp);
        check_value("unmapped read resp", 32'(axil_pkg::RESP_SLVERR), 32'(resp));
        check_cur();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== src.f ====
design/cursor_pkg.sv
design/axil_pkg.sv
design/button_conditioner.sv
design/cursor_tracker.sv
design/position_fifo.sv
design/axil_position_regs.sv
design/cursor_subsystem.sv
verification/cursor_subsystem_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir && \
verilator --binary --timing --assert -Wno-fatal --top-module cursor_subsystem_tb \
    -f src.f -o Vcursor_subsystem_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
{ ./obj_dir/Vcursor_subsystem_tb > sim.log 2>&1 || true; } && \
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" || \
{ echo "simulation failed, see sim.log"; exit 1; }
